// ==== design/id_pkg.sv ====
package id_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int alu_op_w   = 12;

    // inst[31:26]
    localparam logic [5:0] op6_alu  = 6'h00;
    localparam logic [5:0] op6_mem  = 6'h0a;
    localparam logic [5:0] op6_jirl = 6'h13;
    localparam logic [5:0] op6_b    = 6'h14;
    localparam logic [5:0] op6_bl   = 6'h15;
    localparam logic [5:0] op6_beq  = 6'h16;
    localparam logic [5:0] op6_bne  = 6'h17;
    localparam logic [5:0] op6_blt  = 6'h18;
    localparam logic [5:0] op6_bge  = 6'h19;
    localparam logic [5:0] op6_bltu = 6'h1a;
    localparam logic [5:0] op6_bgeu = 6'h1b;

    // inst[31:25], 20-bit immediate forms
    localparam logic [6:0] op7_lu12i     = 7'h0a;
    localparam logic [6:0] op7_pcaddu12i = 7'h0e;

    // inst[25:22]
    localparam logic [3:0] op4_r3    = 4'h0;
    localparam logic [3:0] op4_shift = 4'h1;
    localparam logic [3:0] op4_ld_w  = 4'h2;
    localparam logic [3:0] op4_st_w  = 4'h6;
    localparam logic [3:0] op4_slti  = 4'h8;
    localparam logic [3:0] op4_sltui = 4'h9;
    localparam logic [3:0] op4_addi  = 4'ha;
    localparam logic [3:0] op4_andi  = 4'hd;
    localparam logic [3:0] op4_ori   = 4'he;
    localparam logic [3:0] op4_xori  = 4'hf;

    // inst[21:20]
    localparam logic [1:0] op2_shift = 2'h0;
    localparam logic [1:0] op2_r3    = 2'h1;

    // inst[19:15]
    localparam logic [4:0] op5_add  = 5'h00;
    localparam logic [4:0] op5_slli = 5'h01;
    localparam logic [4:0] op5_sub  = 5'h02;
    localparam logic [4:0] op5_slt  = 5'h04;
    localparam logic [4:0] op5_sltu = 5'h05;
    localparam logic [4:0] op5_nor  = 5'h08;
    localparam logic [4:0] op5_and  = 5'h09;
    localparam logic [4:0] op5_srli = 5'h09;
    localparam logic [4:0] op5_or   = 5'h0a;
    localparam logic [4:0] op5_xor  = 5'h0b;
    localparam logic [4:0] op5_sll  = 5'h0e;
    localparam logic [4:0] op5_srl  = 5'h0f;
    localparam logic [4:0] op5_sra  = 5'h10;
    localparam logic [4:0] op5_srai = 5'h11;

    typedef union packed {
        struct packed {
            logic [16:0] opcode;
            logic [4:0]  rk;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } r3;
        struct packed {
            logic [9:0]  opcode;
            logic [11:0] imm12;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } ri12;
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] imm16;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } ri16;
        struct packed {
            logic [6:0]  opcode;
            logic [19:0] imm20;
            logic [4:0]  rd;
        } ri20;
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs_lo;
            logic [9:0]  offs_hi;
        } i26;
    } inst_t;

    // add sits in bit 0
    typedef struct packed {
        logic lui;
        logic sra;
        logic srl;
        logic sll;
        logic xor_;
        logic or_;
        logic nor_;
        logic and_;
        logic sltu;
        logic slt;
        logic sub;
        logic add;
    } alu_op_t;

    typedef struct packed {
        logic beq;
        logic bne;
        logic blt;
        logic bge;
        logic bltu;
        logic bgeu;
        logic jirl;
        logic b;
        logic bl;
    } br_kind_t;

    typedef struct packed {
        alu_op_t               alu_op;
        br_kind_t              br_kind;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        logic                  res_from_mem;
        logic                  mem_we;
        logic                  gr_we;
        logic                  reads_rj;
        logic                  reads_rkd;
        logic [reg_addr_w-1:0] dest;
        logic [xlen-1:0]       imm;
        logic [xlen-1:0]       offs;
    } id_ctrl_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        inst_t           inst;
    } fs_to_ds_t;

    typedef struct packed {
        alu_op_t               alu_op;
        logic                  src1_is_pc;
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       rj_value;
        logic                  src2_is_imm;
        logic [xlen-1:0]       imm;
        logic [xlen-1:0]       rkd_value;
        logic                  gr_we;
        logic [reg_addr_w-1:0] dest;
        logic                  res_from_mem;
        logic                  mem_we;
    } ds_to_es_t;

    typedef struct packed {
        logic                  valid;
        logic                  we;
        logic                  is_load;
        logic [reg_addr_w-1:0] addr;
        logic [xlen-1:0]       result;
    } fwd_src_t;

    typedef struct packed {
        logic                  valid;
        logic                  we;
        logic [reg_addr_w-1:0] addr;
        logic [xlen-1:0]       data;
    } rf_wr_t;

    typedef struct packed {
        logic            stall;
        logic            taken;
        logic [xlen-1:0] target;
    } br_bus_t;

endpackage

// ==== design/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder import id_pkg::*; (
    input  inst_t                 inst,
    output id_ctrl_t              ctrl,
    output logic [reg_addr_w-1:0] raddr1,
    output logic [reg_addr_w-1:0] raddr2
);

    logic [5:0]          op6;
    logic [3:0]          op4;
    logic [1:0]          op2;
    logic [4:0]          op5;
    logic                is_r3;
    logic                is_shift;
    logic                inst_add;
    logic                inst_sub;
    logic                inst_slt;
    logic                inst_sltu;
    logic                inst_nor;
    logic                inst_and;
    logic                inst_or;
    logic                inst_xor;
    logic                inst_sll;
    logic                inst_srl;
    logic                inst_sra;
    logic                inst_slli;
    logic                inst_srli;
    logic                inst_srai;
    logic                inst_addi;
    logic                inst_slti;
    logic                inst_sltui;
    logic                inst_andi;
    logic                inst_ori;
    logic                inst_xori;
    logic                inst_lu12i;
    logic                inst_pcaddu12i;
    logic                inst_ld_w;
    logic                inst_st_w;
    logic                br_con;
    logic                need_si20;
    logic                need_ui12;
    logic                src2_is_4;
    logic                src_reg_is_rd;
    logic [25:0]         offs26;
    logic [alu_op_w-1:0] alu_vec;

    assign op6 = inst.ri16.opcode;
    assign op4 = inst.ri12.opcode[3:0];
    assign op2 = inst.r3.opcode[6:5];
    assign op5 = inst.r3.opcode[4:0];

    assign is_r3    = (op6 == op6_alu) && (op4 == op4_r3) && (op2 == op2_r3);
    assign is_shift = (op6 == op6_alu) && (op4 == op4_shift) && (op2 == op2_shift);

    assign inst_add  = is_r3 && (op5 == op5_add);
    assign inst_sub  = is_r3 && (op5 == op5_sub);
    assign inst_slt  = is_r3 && (op5 == op5_slt);
    assign inst_sltu = is_r3 && (op5 == op5_sltu);
    assign inst_nor  = is_r3 && (op5 == op5_nor);
    assign inst_and  = is_r3 && (op5 == op5_and);
    assign inst_or   = is_r3 && (op5 == op5_or);
    assign inst_xor  = is_r3 && (op5 == op5_xor);
    assign inst_sll  = is_r3 && (op5 == op5_sll);
    assign inst_srl  = is_r3 && (op5 == op5_srl);
    assign inst_sra  = is_r3 && (op5 == op5_sra);
    assign inst_slli = is_shift && (op5 == op5_slli);
    assign inst_srli = is_shift && (op5 == op5_srli);
    assign inst_srai = is_shift && (op5 == op5_srai);

    assign inst_addi      = (op6 == op6_alu) && (op4 == op4_addi);
    assign inst_slti      = (op6 == op6_alu) && (op4 == op4_slti);
    assign inst_sltui     = (op6 == op6_alu) && (op4 == op4_sltui);
    assign inst_andi      = (op6 == op6_alu) && (op4 == op4_andi);
    assign inst_ori       = (op6 == op6_alu) && (op4 == op4_ori);
    assign inst_xori      = (op6 == op6_alu) && (op4 == op4_xori);
    assign inst_lu12i     = inst.ri20.opcode == op7_lu12i;
    assign inst_pcaddu12i = inst.ri20.opcode == op7_pcaddu12i;
    assign inst_ld_w      = (op6 == op6_mem) && (op4 == op4_ld_w);
    assign inst_st_w      = (op6 == op6_mem) && (op4 == op4_st_w);

    assign ctrl.br_kind.beq  = op6 == op6_beq;
    assign ctrl.br_kind.bne  = op6 == op6_bne;
    assign ctrl.br_kind.blt  = op6 == op6_blt;
    assign ctrl.br_kind.bge  = op6 == op6_bge;
    assign ctrl.br_kind.bltu = op6 == op6_bltu;
    assign ctrl.br_kind.bgeu = op6 == op6_bgeu;
    assign ctrl.br_kind.jirl = op6 == op6_jirl;
    assign ctrl.br_kind.b    = op6 == op6_b;
    assign ctrl.br_kind.bl   = op6 == op6_bl;

    assign br_con = ctrl.br_kind.beq | ctrl.br_kind.bne | ctrl.br_kind.blt
                  | ctrl.br_kind.bge | ctrl.br_kind.bltu | ctrl.br_kind.bgeu;

    // msb first: lui sra srl sll xor or nor and sltu slt sub add
    assign alu_vec = {
        inst_lu12i,
        inst_sra | inst_srai,
        inst_srl | inst_srli,
        inst_sll | inst_slli,
        inst_xor | inst_xori,
        inst_or | inst_ori,
        inst_nor,
        inst_and | inst_andi,
        inst_sltu | inst_sltui,
        inst_slt | inst_slti,
        inst_sub,
        inst_add | inst_addi | inst_ld_w | inst_st_w | ctrl.br_kind.jirl
            | ctrl.br_kind.bl | inst_pcaddu12i
    };
    assign ctrl.alu_op = alu_op_t'(alu_vec);

    assign need_si20 = inst_lu12i | inst_pcaddu12i;
    assign need_ui12 = inst_andi | inst_ori | inst_xori;
    // link value for jirl and bl is pc + 4
    assign src2_is_4 = ctrl.br_kind.jirl | ctrl.br_kind.bl;

    // shift amount sits in imm12[4:0], the sign-extended form covers it
    assign ctrl.imm = src2_is_4 ? 32'd4 :
                      need_si20 ? {inst.ri20.imm20, 12'b0} :
                      need_ui12 ? {20'b0, inst.ri12.imm12} :
                      {{20{inst.ri12.imm12[11]}}, inst.ri12.imm12};

    assign offs26    = {inst.i26.offs_hi, inst.i26.offs_lo};
    assign ctrl.offs = (ctrl.br_kind.b | ctrl.br_kind.bl) ?
                       {{4{offs26[25]}}, offs26, 2'b0} :
                       {{14{inst.ri16.imm16[15]}}, inst.ri16.imm16, 2'b0};

    assign src_reg_is_rd = br_con | inst_st_w;
    assign raddr1        = inst.r3.rj;
    assign raddr2        = src_reg_is_rd ? inst.r3.rd : inst.r3.rk;

    assign ctrl.dest         = ctrl.br_kind.bl ? 5'd1 : inst.r3.rd;
    assign ctrl.gr_we        = ~inst_st_w & ~ctrl.br_kind.b & ~br_con;
    assign ctrl.src1_is_pc   = ctrl.br_kind.jirl | ctrl.br_kind.bl | inst_pcaddu12i;
    assign ctrl.src2_is_imm  = inst_slli | inst_srli | inst_srai | inst_addi | inst_slti
                             | inst_sltui | inst_andi | inst_ori | inst_xori | inst_ld_w
                             | inst_st_w | need_si20 | src2_is_4;
    assign ctrl.res_from_mem = inst_ld_w;
    assign ctrl.mem_we       = inst_st_w;

    assign ctrl.reads_rj  = ~(ctrl.br_kind.b | ctrl.br_kind.bl | need_si20);
    assign ctrl.reads_rkd = src_reg_is_rd | inst_add | inst_sub | inst_slt | inst_sltu
                          | inst_nor | inst_and | inst_or | inst_xor | inst_sll
                          | inst_srl | inst_sra;

endmodule

// ==== design/regfile.sv ====
`timescale 1ns/1ps

module regfile import id_pkg::*; (
    input  logic                  clk,
    input  rf_wr_t                wr,
    input  logic [reg_addr_w-1:0] raddr1,
    input  logic [reg_addr_w-1:0] raddr2,
    output logic [xlen-1:0]       rdata1,
    output logic [xlen-1:0]       rdata2
);

    // r0 has no storage
    logic [xlen-1:0] regs [31:1];

    always_ff @(posedge clk) begin
        if (wr.valid && wr.we && (wr.addr != '0)) begin
            regs[wr.addr] <= wr.data;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== design/operand_bypass.sv ====
`timescale 1ns/1ps

module operand_bypass import id_pkg::*; (
    input  logic [reg_addr_w-1:0] raddr1,
    input  logic [reg_addr_w-1:0] raddr2,
    input  logic                  reads_rj,
    input  logic                  reads_rkd,
    input  logic [xlen-1:0]       rdata1,
    input  logic [xlen-1:0]       rdata2,
    input  fwd_src_t              es_fwd,
    input  fwd_src_t              ms_fwd,
    input  rf_wr_t                ws_wr,
    output logic [xlen-1:0]       rj_value,
    output logic [xlen-1:0]       rkd_value,
    output logic                  stall
);

    logic load_hit1;
    logic load_hit2;

    // newest producer wins, execute loads have no data yet
    function automatic logic [xlen-1:0] pick(
        input logic [reg_addr_w-1:0] addr,
        input logic [xlen-1:0]       rf_data,
        input fwd_src_t              es,
        input fwd_src_t              ms,
        input rf_wr_t                ws
    );
        logic [xlen-1:0] value;
        if (addr == '0)
            value = '0;
        else if (es.valid && es.we && !es.is_load && (es.addr == addr))
            value = es.result;
        else if (ms.valid && ms.we && (ms.addr == addr))
            value = ms.result;
        else if (ws.valid && ws.we && (ws.addr == addr))
            value = ws.data;
        else
            value = rf_data;
        return value;
    endfunction

    assign rj_value  = pick(raddr1, rdata1, es_fwd, ms_fwd, ws_wr);
    assign rkd_value = pick(raddr2, rdata2, es_fwd, ms_fwd, ws_wr);

    assign load_hit1 = reads_rj && (raddr1 != '0) && (raddr1 == es_fwd.addr);
    assign load_hit2 = reads_rkd && (raddr2 != '0) && (raddr2 == es_fwd.addr);
    assign stall     = es_fwd.valid && es_fwd.is_load && (load_hit1 || load_hit2);

endmodule

// ==== design/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit import id_pkg::*; (
    input  logic            ds_valid,
    input  logic            stall,
    input  br_kind_t        br_kind,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] rj_value,
    input  logic [xlen-1:0] rkd_value,
    input  logic [xlen-1:0] offs,
    output br_bus_t         br
);

    logic br_con;
    logic eq;
    logic ge_s;
    logic ge_u;
    logic cond_met;

    assign br_con = br_kind.beq | br_kind.bne | br_kind.blt
                  | br_kind.bge | br_kind.bltu | br_kind.bgeu;

    assign eq   = rj_value == rkd_value;
    assign ge_s = $signed(rj_value) >= $signed(rkd_value);
    assign ge_u = rj_value >= rkd_value;

    assign cond_met = (br_kind.beq & eq) | (br_kind.bne & ~eq)
                    | (br_kind.bge & ge_s) | (br_kind.blt & ~ge_s)
                    | (br_kind.bgeu & ge_u) | (br_kind.bltu & ~ge_u);

    // operands are stale while stalled
    assign br.taken  = (cond_met | br_kind.jirl | br_kind.b | br_kind.bl) & ds_valid & ~stall;
    assign br.target = br_kind.jirl ? (rj_value + offs) : (pc + offs);
    assign br.stall  = ds_valid & stall & br_con;

endmodule

// ==== design/id_stage.sv ====
`timescale 1ns/1ps

module id_stage import id_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      flush,
    input  logic      fs_to_ds_valid,
    input  fs_to_ds_t fs_to_ds,
    output logic      ds_allowin,
    input  logic      es_allowin,
    output logic      ds_to_es_valid,
    output ds_to_es_t ds_to_es,
    input  fwd_src_t  es_fwd,
    input  fwd_src_t  ms_fwd,
    input  rf_wr_t    ws_wr,
    output br_bus_t   br_bus
);

    logic                  ds_valid;
    fs_to_ds_t             fs_to_ds_r;
    id_ctrl_t              ctrl;
    logic [reg_addr_w-1:0] raddr1;
    logic [reg_addr_w-1:0] raddr2;
    logic [xlen-1:0]       rdata1;
    logic [xlen-1:0]       rdata2;
    logic [xlen-1:0]       rj_value;
    logic [xlen-1:0]       rkd_value;
    logic                  stall;

    assign ds_allowin     = !ds_valid || flush || (!stall && es_allowin);
    assign ds_to_es_valid = ds_valid && !stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (flush) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            fs_to_ds_r <= fs_to_ds;
        end
    end

    inst_decoder u_decoder (
        .inst   (fs_to_ds_r.inst),
        .ctrl   (ctrl),
        .raddr1 (raddr1),
        .raddr2 (raddr2)
    );

    regfile u_regfile (
        .clk    (clk),
        .wr     (ws_wr),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    operand_bypass u_bypass (
        .raddr1    (raddr1),
        .raddr2    (raddr2),
        .reads_rj  (ctrl.reads_rj),
        .reads_rkd (ctrl.reads_rkd),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .es_fwd    (es_fwd),
        .ms_fwd    (ms_fwd),
        .ws_wr     (ws_wr),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .stall     (stall)
    );

    branch_unit u_branch (
        .ds_valid  (ds_valid),
        .stall     (stall),
        .br_kind   (ctrl.br_kind),
        .pc        (fs_to_ds_r.pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .offs      (ctrl.offs),
        .br        (br_bus)
    );

    always_comb begin
        ds_to_es.alu_op       = ctrl.alu_op;
        ds_to_es.src1_is_pc   = ctrl.src1_is_pc;
        ds_to_es.pc           = fs_to_ds_r.pc;
        ds_to_es.rj_value     = rj_value;
        ds_to_es.src2_is_imm  = ctrl.src2_is_imm;
        ds_to_es.imm          = ctrl.imm;
        ds_to_es.rkd_value    = rkd_value;
        ds_to_es.gr_we        = ctrl.gr_we;
        ds_to_es.dest         = ctrl.dest;
        ds_to_es.res_from_mem = ctrl.res_from_mem;
        ds_to_es.mem_we       = ctrl.mem_we;
    end

endmodule

// ==== verif/id_checks.svh ====
`ifndef ID_CHECKS_SVH
`define ID_CHECKS_SVH

int pass_cnt = 0;
int fail_cnt = 0;

// decoded bus towards execute, compared field for field in one word
task automatic check_exe(input string name, input ds_to_es_t exp, input ds_to_es_t act);
    if (act !== exp) begin
        fail_cnt++;
        $display("FAILED %s expected %h actual %h", name, exp, act);
    end else begin
        pass_cnt++;
        $display("ok     %s", name);
    end
endtask

task automatic check_br(input string name, input br_bus_t exp, input br_bus_t act);
    if (act !== exp) begin
        fail_cnt++;
        $display("FAILED %s expected stall %b taken %b target %h actual stall %b taken %b target %h",
                 name, exp.stall, exp.taken, exp.target, act.stall, act.taken, act.target);
    end else begin
        pass_cnt++;
        $display("ok     %s", name);
    end
endtask

// handshake and control problems that have no single value to show
task automatic report_problem(input string name, input string what);
    fail_cnt++;
    $display("FAILED %s %s", name, what);
endtask

task automatic report_ok(input string name);
    pass_cnt++;
    $display("ok     %s", name);
endtask

`endif

// ==== verif/id_stage_tb.sv ====
`timescale 1ns/1ps

module id_stage_tb import id_pkg::*; ();

    logic      clk;
    logic      reset;
    logic      flush;
    logic      fs_to_ds_valid;
    fs_to_ds_t fs_to_ds;
    logic      ds_allowin;
    logic      es_allowin;
    logic      ds_to_es_valid;
    ds_to_es_t ds_to_es;
    fwd_src_t  es_fwd;
    fwd_src_t  ms_fwd;
    rf_wr_t    ws_wr;
    br_bus_t   br_bus;

    // columns: inst pc esf esa esr msf msa msr wsf wsa wsd x0..x7
    string       t_name [0:63];
    string       t_kind [0:63];
    logic [31:0] fld    [0:63][0:18];
    int          n_lines = 0;
    logic [31:0] rand_state = 32'd50790;
    int          fd;
    int          n;
    string       line;

    `include "id_checks.svh"

    id_stage DUT (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds       (fs_to_ds),
        .ds_allowin     (ds_allowin),
        .es_allowin     (es_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es       (ds_to_es),
        .es_fwd         (es_fwd),
        .ms_fwd         (ms_fwd),
        .ws_wr          (ws_wr),
        .br_bus         (br_bus)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rand_state = rand_state ^ (rand_state << 13);
        rand_state = rand_state ^ (rand_state >> 17);
        rand_state = rand_state ^ (rand_state << 5);
        return rand_state;
    endfunction

    function automatic fwd_src_t make_es(input int i);
        fwd_src_t f;
        f.valid   = fld[i][2][2];
        f.we      = fld[i][2][1];
        f.is_load = fld[i][2][0];
        f.addr    = fld[i][3][4:0];
        f.result  = fld[i][4];
        return f;
    endfunction

    function automatic fwd_src_t make_ms(input int i);
        fwd_src_t f;
        f.valid   = fld[i][5][1];
        f.we      = fld[i][5][0];
        f.is_load = 1'b0;
        f.addr    = fld[i][6][4:0];
        f.result  = fld[i][7];
        return f;
    endfunction

    function automatic rf_wr_t make_ws(input int i);
        rf_wr_t w;
        w.valid = fld[i][8][1];
        w.we    = fld[i][8][0];
        w.addr  = fld[i][9][4:0];
        w.data  = fld[i][10];
        return w;
    endfunction

    function automatic ds_to_es_t expected_exe(input int i);
        ds_to_es_t e;
        e.alu_op       = alu_op_t'(fld[i][17][11:0]);
        e.src1_is_pc   = fld[i][18][3];
        e.pc           = fld[i][1];
        e.rj_value     = fld[i][12];
        e.src2_is_imm  = fld[i][18][2];
        e.imm          = fld[i][14];
        e.rkd_value    = fld[i][13];
        e.gr_we        = fld[i][16][0];
        e.dest         = fld[i][15][4:0];
        e.res_from_mem = fld[i][18][1];
        e.mem_we       = fld[i][18][0];
        return e;
    endfunction

    function automatic br_bus_t expected_br(input int i);
        br_bus_t b;
        b.stall  = 1'b0;
        b.taken  = fld[i][11][0];
        b.target = fld[i][12];
        return b;
    endfunction

    // quiet compare for cycles where the result must hold
    function automatic bit outputs_match(input int i);
        bit ok;
        ok = 1'b1;
        if (t_kind[i] == "exe")
            ok = (ds_to_es === expected_exe(i));
        else if (t_kind[i] == "br")
            ok = (br_bus === expected_br(i));
        return ok;
    endfunction

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        rf_wr_t w;
        w.valid = 1'b1;
        w.we    = 1'b1;
        w.addr  = addr;
        w.data  = data;
        @(posedge clk);
        ws_wr <= w;
        @(posedge clk);
        ws_wr <= '0;
    endtask

    task automatic clear_regfile();
        for (int r = 1; r < 32; r++) begin
            write_reg(r[4:0], 32'h0);
        end
    endtask

    task automatic run_test(input int i);
        fs_to_ds_t fs;
        int        holds;
        fs.pc   = fld[i][1];
        fs.inst = inst_t'(fld[i][0]);
        @(posedge clk);
        fs_to_ds_valid <= 1'b1;
        fs_to_ds       <= fs;
        es_fwd         <= make_es(i);
        ms_fwd         <= make_ms(i);
        es_allowin     <= 1'b0;
        // acceptance edge
        @(posedge clk);
        fs_to_ds_valid <= 1'b0;
        // lands in the regfile one edge after the first look
        ws_wr          <= make_ws(i);
        if (t_kind[i] == "exe" && fld[i][11][0]) begin
            @(posedge clk);
            es_allowin <= 1'b1;
            @(negedge clk);
            if (ds_to_es_valid !== 1'b0 || ds_allowin !== 1'b0)
                report_problem(t_name[i], "load-use hazard did not stall the stage");
            if (!outputs_match(i))
                report_problem(t_name[i], "wrong operands while stalled on the load");
            @(posedge clk);
            es_allowin <= 1'b0;
            es_fwd     <= '0;
        end
        @(negedge clk);
        while (ds_to_es_valid !== 1'b1) begin
            @(negedge clk);
        end
        if (t_kind[i] == "exe")
            check_exe(t_name[i], expected_exe(i), ds_to_es);
        else if (t_kind[i] == "br")
            check_br(t_name[i], expected_br(i), br_bus);
        holds = int'(next_rand() % 32'd4);
        repeat (holds) begin
            @(negedge clk);
            if (ds_allowin !== 1'b0)
                report_problem(t_name[i], "stage took new input while execute was blocked");
            if (ds_to_es_valid !== 1'b1 || !outputs_match(i))
                report_problem(t_name[i], "outputs changed while execute was blocked");
        end
        if (t_kind[i] == "fl") begin
            @(posedge clk);
            flush <= 1'b1;
            @(posedge clk);
            flush  <= 1'b0;
            es_fwd <= '0;
            ms_fwd <= '0;
            ws_wr  <= '0;
            @(negedge clk);
            if (ds_to_es_valid !== 1'b0 || br_bus.taken !== 1'b0)
                report_problem(t_name[i], "stage still valid or branch taken after flush");
            else
                report_ok(t_name[i]);
        end else begin
            @(posedge clk);
            es_allowin <= 1'b1;
            // transfer edge
            @(posedge clk);
            es_allowin <= 1'b0;
            es_fwd     <= '0;
            ms_fwd     <= '0;
            ws_wr      <= '0;
        end
    endtask

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        flush          = 1'b0;
        fs_to_ds_valid = 1'b0;
        fs_to_ds       = '0;
        es_allowin     = 1'b0;
        es_fwd         = '0;
        ms_fwd         = '0;
        ws_wr          = '0;

        fd = $fopen("verif/id_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            $display("Test failed");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 3 || line[0] == "#")
                    continue;
                n = $sscanf(line,
                    "%s %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    t_name[n_lines], t_kind[n_lines], fld[n_lines][0], fld[n_lines][1],
                    fld[n_lines][2], fld[n_lines][3], fld[n_lines][4], fld[n_lines][5],
                    fld[n_lines][6], fld[n_lines][7], fld[n_lines][8], fld[n_lines][9],
                    fld[n_lines][10], fld[n_lines][11], fld[n_lines][12], fld[n_lines][13],
                    fld[n_lines][14], fld[n_lines][15], fld[n_lines][16], fld[n_lines][17],
                    fld[n_lines][18]);
                if (n == 21)
                    n_lines++;
                else
                    report_problem("stimulus", "malformed line in the stimulus file");
            end
            $fclose(fd);

            repeat (16) @(posedge clk);
            reset <= 1'b0;
            @(negedge clk);
            if (ds_to_es_valid !== 1'b0 || br_bus.taken !== 1'b0 || br_bus.stall !== 1'b0)
                report_problem("reset", "stage not empty after reset");
            else
                report_ok("reset");
            clear_regfile();

            for (int i = 0; i < n_lines; i++) begin
                if (t_kind[i] == "wr")
                    write_reg(fld[i][9][4:0], fld[i][10]);
                else
                    run_test(i);
            end

            repeat (2) @(posedge clk);
            $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
            if (fail_cnt == 0)
                $display("Test passed");
            else
                $display("Test failed");
            $finish;
        end
    end

    // budget covers reset, the regfile clear and 40 cycles per line
    initial begin
        wait (n_lines > 0);
        #((n_lines * 40 + 80) * 4);
        $display("timeout: the run did not finish in the expected time");
        $display("Test failed");
        $finish;
    end

endmodule

// ==== verif/id_stim.txt ====
# name kind inst pc | es: flags(v we ld) addr res | ms: flags(v we) addr res | ws: flags addr data
# exe: stall rj rkd imm dest gr_we alu_op flags(pc imm mem st) | br: taken target, rest 0
pre_r1 wr 0 0 0 00 00000000 0 00 00000000 3 01 11111111 0 0 0 0 0 0 0 0
pre_r2 wr 0 0 0 00 00000000 0 00 00000000 3 02 22222222 0 0 0 0 0 0 0 0
pre_r3 wr 0 0 0 00 00000000 0 00 00000000 3 03 80000000 0 0 0 0 0 0 0 0
pre_r4 wr 0 0 0 00 00000000 0 00 00000000 3 04 00000005 0 0 0 0 0 0 0 0
pre_r5 wr 0 0 0 00 00000000 0 00 00000000 3 05 fffffff0 0 0 0 0 0 0 0 0
add_rf exe 00100826 1c000000 0 00 00000000 0 00 00000000 0 00 00000000 0 11111111 22222222 00000402 06 1 001 0
sub_r0 exe 00110807 1c000004 0 00 00000000 0 00 00000000 0 00 00000000 0 00000000 22222222 00000442 07 1 002 0
addi_neg exe 02bffc28 1c000008 0 00 00000000 0 00 00000000 0 00 00000000 0 11111111 00000000 ffffffff 08 1 001 4
andi_zext exe 0363c049 1c00000c 0 00 00000000 0 00 00000000 0 00 00000000 0 22222222 00000000 000008f0 09 1 010 4
slti_min exe 0220006a 1c000010 0 00 00000000 0 00 00000000 0 00 00000000 0 80000000 00000000 fffff800 0a 1 004 4
lu12i exe 1500002b 1c000014 0 00 00000000 0 00 00000000 0 00 00000000 0 11111111 00000000 80001000 0b 1 800 4
pcaddu12i exe 1c00020c 1c000100 0 00 00000000 0 00 00000000 0 00 00000000 0 00000000 00000000 00010000 0c 1 001 c
ld_w exe 2880208d 1c000018 0 00 00000000 0 00 00000000 0 00 00000000 0 00000005 00000000 00000008 0d 1 001 6
st_w exe 299ff022 1c00001c 0 00 00000000 0 00 00000000 0 00 00000000 0 11111111 22222222 000007fc 02 0 001 5
jirl_link exe 4c001041 1c000020 0 00 00000000 0 00 00000000 0 00 00000000 0 22222222 00000005 00000004 01 1 001 c
bl_link exe 54004000 1c000024 0 00 00000000 0 00 00000000 0 00 00000000 0 00000000 00000000 00000004 01 1 001 c
fwd_prio exe 00105686 1c000030 6 14 aaaa0014 3 14 bbbb0014 3 15 cccc0015 0 aaaa0014 cccc0015 00000415 06 1 001 0
fwd_load_use exe 00105686 1c000034 7 14 deadbeef 3 14 bbbb1014 3 15 dddd0015 1 bbbb1014 dddd0015 00000415 06 1 001 0
fwd_ws exe 00105686 1c000038 0 00 00000000 2 14 12345678 3 14 eeee0014 0 eeee0014 dddd0015 00000415 06 1 001 0
rf_after_ws exe 00105686 1c00003c 0 00 00000000 0 00 00000000 0 00 00000000 0 eeee0014 dddd0015 00000415 06 1 001 0
store_load_use exe 299ff022 1c000040 7 02 deadbeef 0 00 00000000 0 00 00000000 1 11111111 22222222 000007fc 02 0 001 5
load_no_hit exe 00100826 1c000044 7 09 deadbeef 0 00 00000000 0 00 00000000 0 11111111 22222222 00000402 06 1 001 0
beq_eq br 58002021 1c000000 0 00 00000000 0 00 00000000 0 00 00000000 1 1c000020 0 0 0 0 0 0
beq_ne br 58002022 1c000000 0 00 00000000 0 00 00000000 0 00 00000000 0 1c000020 0 0 0 0 0 0
bne_ne br 5c002022 1c000000 0 00 00000000 0 00 00000000 0 00 00000000 1 1c000020 0 0 0 0 0 0
bne_back br 5ffff022 1c000100 0 00 00000000 0 00 00000000 0 00 00000000 1 1c0000f0 0 0 0 0 0 0
blt_less br 60002064 1c000000 0 00 00000000 0 00 00000000 0 00 00000000 1 1c000020 0 0 0 0 0 0
blt_more br 60002083 1c000000 0 00 00000000 0 00 00000000 0 00 00000000 0 1c000020 0 0 0 0 0 0
bge_eq br 64002084 1c000000 0 00 00000000 0 00 00000000 0 00 00000000 1 1c000020 0 0 0 0 0 0
bge_less br 64002064 1c000000 0 00 00000000 0 00 00000000 0 00 00000000 0 1c000020 0 0 0 0 0 0
bltu_big br 68002064 1c000000 0 00 00000000 0 00 00000000 0 00 00000000 0 1c000020 0 0 0 0 0 0
bltu_less br 68002085 1c000000 0 00 00000000 0 00 00000000 0 00 00000000 1 1c000020 0 0 0 0 0 0
bgeu_big br 6c002064 1c000000 0 00 00000000 0 00 00000000 0 00 00000000 1 1c000020 0 0 0 0 0 0
bgeu_eq br 6c0020a5 1c000000 0 00 00000000 0 00 00000000 0 00 00000000 1 1c000020 0 0 0 0 0 0
jirl_jump br 4c001041 1c000000 0 00 00000000 0 00 00000000 0 00 00000000 1 22222232 0 0 0 0 0 0
b_jump br 50004000 1c000000 0 00 00000000 0 00 00000000 0 00 00000000 1 1c000040 0 0 0 0 0 0
bl_jump br 54004000 1c000200 0 00 00000000 0 00 00000000 0 00 00000000 1 1c000240 0 0 0 0 0 0
flush_b fl 50004000 1c000300 0 00 00000000 0 00 00000000 0 00 00000000 0 0 0 0 0 0 0 0

// ==== sim.f ====
+incdir+verif
design/id_pkg.sv
design/inst_decoder.sv
design/regfile.sv
design/operand_bypass.sv
design/branch_unit.sv
design/id_stage.sv
verif/id_stage_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -f sim.f --top-module id_stage_tb -Mdir obj_dir
	./obj_dir/Vid_stage_tb | tee sim.log
	grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log
